// ==== logic/vstore_pkg.sv ====
// shared widths, opcode and LMUL encodings
// and the bank beat struct for the vector store unit
`default_nettype none

package vstore_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // one data memory bank word
    parameter int WORD_W = 32;
    // banks written side by side on every beat
    parameter int NUM_BANKS = 4;
    // one beat covers all banks
    parameter int BEAT_W = NUM_BANKS * WORD_W;
    // LMUL_4 needs four beats
    parameter int MAX_BEATS = 4;
    // register group data, up to four vector registers of 128 bits
    parameter int STORE_DATA_W = MAX_BEATS * BEAT_W;
    // word address into the data memory
    parameter int ADDR_W_DEFAULT = 14;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // store opcodes from the vector LSU decode
    // only the unit-stride codes are handled here
    typedef enum logic [3:0] {
        VLSU_VSE8  = 4'd7,
        VLSU_VSE16 = 4'd8,
        VLSU_VSE32 = 4'd9
    } store_op_e;

    // register group multiplier, codes 3..7 reserved
    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2
    } lmul_e;

    // beats still to be written, 0..MAX_BEATS
    typedef logic [2:0] beat_cnt_t;

    // write data of one beat
    // bank0 sits in the low word so a plain 128-bit slice casts straight in
    typedef struct packed {
        logic [WORD_W-1:0] bank3;
        logic [WORD_W-1:0] bank2;
        logic [WORD_W-1:0] bank1;
        logic [WORD_W-1:0] bank0;
    } bank_beat_t;

endpackage

`default_nettype wire

// ==== logic/vstore_ctrl.sv ====
// store sequencer FSM
// accepts unit-stride requests and runs the write beats
`timescale 1ns/100ps
`default_nettype none

module vstore_ctrl
    import vstore_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      start,
    input  store_op_e store_op,
    // from the beat counter, final beat is on
    input  logic      last,
    output logic      load,
    output logic      step,
    output logic      busy,
    output logic      dm_v_write,
    output logic      done
);

    //////////////////////////////
    // state
    //////////////////////////////

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WRITE = 2'd1,
        DONE  = 2'd2
    } state_e;

    state_e state;
    state_e state_nxt;

    // only VSE8/16/32 start a store, byte layout is the same for all three
    logic op_valid;
    logic accept;

    assign op_valid = (store_op == VLSU_VSE8) ||
                      (store_op == VLSU_VSE16) ||
                      (store_op == VLSU_VSE32);

    // start is only looked at while idle
    // so a second strobe during a store is dropped
    assign accept = (state == IDLE) && start && op_valid;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                // one write per cycle until the counter flags the final beat
                if (last) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    //////////////////////////////
    // strobes
    //////////////////////////////

    // capture pulse for counter, address and data registers
    assign load = accept;

    assign dm_v_write = (state == WRITE);

    // advance to the next beat
    // not raised on the final one, so address and data hold that beat afterwards
    assign step = dm_v_write && !last;

    // covers the write beats and the done cycle
    assign busy = (state != IDLE);

    assign done = (state == DONE);

endmodule

`default_nettype wire

// ==== logic/vstore_beat_counter.sv ====
// beat counter, loads the beat count from LMUL and flags the final beat
`timescale 1ns/100ps
`default_nettype none

module vstore_beat_counter
    import vstore_pkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  logic  load,
    input  logic  step,
    input  lmul_e lmul,
    output logic  last
);

    beat_cnt_t remaining;
    beat_cnt_t load_cnt;

    // one 128-bit beat per vector register in the group
    always_comb begin
        case (lmul)
            LMUL_1:  load_cnt = beat_cnt_t'(1);
            LMUL_2:  load_cnt = beat_cnt_t'(2);
            LMUL_4:  load_cnt = beat_cnt_t'(MAX_BEATS);
            // reserved codes fall back to a single beat
            default: load_cnt = beat_cnt_t'(1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= load_cnt;
        end else if (step) begin
            remaining <= remaining - beat_cnt_t'(1);
        end
    end

    // combinational, valid in the same cycle as the final beat
    assign last = (remaining == beat_cnt_t'(1));

endmodule

`default_nettype wire

// ==== logic/vstore_addr_gen.sv ====
// running base address and the four consecutive bank word addresses
`timescale 1ns/100ps
`default_nettype none

module vstore_addr_gen
    import vstore_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEFAULT
)(
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            load,
    input  logic                            step,
    input  logic [ADDR_W-1:0]               address,
    output logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr
);

    // word address of bank0 for the current beat
    logic [ADDR_W-1:0] base;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            base <= '0;
        end else if (load) begin
            base <= address;
        end else if (step) begin
            // next beat starts right after the four words just written
            base <= base + ADDR_W'(NUM_BANKS);
        end
    end

    // bank i takes word base+i, wraps at the top of the address space
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        assign bank_addr[i] = base + ADDR_W'(i);
    end

endmodule

`default_nettype wire

// ==== logic/vstore_data_shift.sv ====
// register group data holder, presents one 128-bit beat per cycle
`timescale 1ns/100ps
`default_nettype none

module vstore_data_shift
    import vstore_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    load,
    input  logic                    step,
    input  logic [STORE_DATA_W-1:0] data,
    output bank_beat_t              bank_data
);

    // current beat always sits in the low BEAT_W bits
    logic [STORE_DATA_W-1:0] data_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            data_q <= '0;
        end else if (load) begin
            data_q <= data;
        end else if (step) begin
            // drop the beat just written, zeros fill from the top
            data_q <= data_q >> BEAT_W;
        end
    end

    // word i of the beat goes to bank i
    assign bank_data = bank_beat_t'(data_q[BEAT_W-1:0]);

endmodule

`default_nettype wire

// ==== logic/vstore_unit.sv ====
// vector store unit top
// FSM, beat counter, address generator and data shifter
`timescale 1ns/100ps
`default_nettype none

module vstore_unit
    import vstore_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEFAULT
)(
    input  logic                             clk,
    input  logic                             nrst,
    // request
    input  logic                             start,
    input  store_op_e                        store_op,
    input  lmul_e                            lmul,
    input  logic [ADDR_W-1:0]                address,
    input  logic [STORE_DATA_W-1:0]          data,
    // status
    output logic                             busy,
    // bank write port, no back-pressure
    output logic                             dm_v_write,
    output logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr,
    output bank_beat_t                       bank_data,
    output logic                             done
);

    //////////////////////////////
    // internal strobes
    //////////////////////////////

    // request captured this cycle
    logic load;
    // move to the next beat at the end of this cycle
    logic step;
    // final beat of the store
    logic last;

    vstore_ctrl vstore_ctrl_i (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .store_op   (store_op),
        .last       (last),
        .load       (load),
        .step       (step),
        .busy       (busy),
        .dm_v_write (dm_v_write),
        .done       (done)
    );

    vstore_beat_counter vstore_beat_counter_i (
        .clk  (clk),
        .nrst (nrst),
        .load (load),
        .step (step),
        .lmul (lmul),
        .last (last)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////

    // address and data advance in lockstep, both hold the final beat
    vstore_addr_gen #(
        .ADDR_W (ADDR_W)
    ) vstore_addr_gen_i (
        .clk       (clk),
        .nrst      (nrst),
        .load      (load),
        .step      (step),
        .address   (address),
        .bank_addr (bank_addr)
    );

    vstore_data_shift vstore_data_shift_i (
        .clk       (clk),
        .nrst      (nrst),
        .load      (load),
        .step      (step),
        .data      (data),
        .bank_data (bank_data)
    );

endmodule

`default_nettype wire

// ==== tb/vstore_unit_asserts.sv ====
// concurrent checks on the store unit strobes, bound into the top level
`timescale 1ns/100ps
`default_nettype none

module vstore_unit_asserts (
    input logic clk,
    input logic nrst,
    input logic busy,
    input logic dm_v_write,
    input logic done
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else $error("done held high for more than one cycle");

    // done follows the last beat, never overlaps it
    done_not_write: assert property (@(posedge clk) disable iff (!nrst) !(done && dm_v_write))
        else $error("done and dm_v_write high together");

    write_in_busy: assert property (@(posedge clk) disable iff (!nrst) dm_v_write |-> busy)
        else $error("dm_v_write high while busy is low");

    // synchronous reset clears all strobes one edge later
    reset_quiet: assert property (@(posedge clk) !nrst |=> (!busy && !dm_v_write && !done))
        else $error("strobe high during reset");

endmodule

bind vstore_unit vstore_unit_asserts vstore_unit_asserts_i (
    .clk        (clk),
    .nrst       (nrst),
    .busy       (busy),
    .dm_v_write (dm_v_write),
    .done       (done)
);

`default_nettype wire

// ==== tb/tb_vstore_unit.sv ====
// testbench for the vector store unit
// LFSR stimulus, word memory model and per-beat checks
`timescale 1ns/100ps
`default_nettype none

module tb_vstore_unit
    import vstore_pkg::*;
();

    localparam int ADDR_W = ADDR_W_DEFAULT;
    // cycles allowed from start to done, and for the whole run
    localparam int STORE_TIMEOUT = 16;
    localparam int RUN_LIMIT = 4000;

    logic                             clk;
    logic                             nrst;
    logic                             start;
    store_op_e                        store_op;
    lmul_e                            lmul;
    logic [ADDR_W-1:0]                address;
    logic [STORE_DATA_W-1:0]          data;
    logic                             busy;
    logic                             dm_v_write;
    logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr;
    bank_beat_t                       bank_data;
    logic                             done;

    // expected word per bank address for the store in flight
    logic [WORD_W-1:0] model_mem [int];
    logic [31:0]       lfsr_state;
    string             test_name;
    int                error_count;
    int                test_base;
    int                tests_run;
    int                tests_failed;

    vstore_unit #(.ADDR_W(ADDR_W)) vstore_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hard stop in case a store never finishes
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("run stopped after %0d cycles without finishing", RUN_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // right-shifting galois LFSR, tap mask 0x80200003
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken, low bits first
    task automatic take_bits(input int n, output logic [STORE_DATA_W-1:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[b] = lfsr_state[0];
        end
    endtask

    // beats per LMUL code, reserved codes write a single beat
    function automatic int beats_for_lmul(input lmul_e lm);
        case (lm)
            LMUL_2:  return 2;
            LMUL_4:  return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic [WORD_W-1:0] bank_word(input bank_beat_t beat, input int i);
        case (i)
            0:       return beat.bank0;
            1:       return beat.bank1;
            2:       return beat.bank2;
            default: return beat.bank3;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_base = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == test_base) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, error_count - test_base);
            tests_failed++;
        end
    endtask

    // one store from start to done, every write beat checked against the model
    // poke raises start again with other fields one cycle into the store
    task automatic run_store(input store_op_e op, input lmul_e lm, input bit poke);
        logic [STORE_DATA_W-1:0] rnd;
        logic [ADDR_W-1:0]       base;
        logic [ADDR_W-1:0]       word_addr;
        int                      beats;
        int                      writes;
        int                      first_write;
        int                      done_cycle;
        int                      cycle;
        take_bits(ADDR_W, rnd);
        base = rnd[ADDR_W-1:0];
        take_bits(STORE_DATA_W, rnd);
        beats = beats_for_lmul(lm);
        // data word w lands at base+w, w = 4k+i for beat k bank i
        model_mem.delete();
        for (int w = 0; w < NUM_BANKS * beats; w++) begin
            model_mem[int'(base + ADDR_W'(w))] = rnd[WORD_W*w +: WORD_W];
        end
        @(posedge clk);
        #2;
        start = 1'b1;
        store_op = op;
        lmul = lm;
        address = base;
        data = rnd;
        writes = 0;
        first_write = -1;
        done_cycle = -1;
        cycle = 0;
        while (done_cycle < 0 && cycle < STORE_TIMEOUT) begin
            @(posedge clk);
            #2;
            start = poke && (cycle == 1);
            if (start) begin
                address = ~base;
                data = ~rnd;
                lmul = LMUL_4;
            end
            // outputs settled mid-cycle
            @(negedge clk);
            // busy covers every write beat and the done cycle
            check_value("busy", 64'(1), 64'(busy));
            if (dm_v_write) begin
                if (first_write < 0) begin
                    first_write = cycle;
                end
                for (int i = 0; i < NUM_BANKS; i++) begin
                    word_addr = base + ADDR_W'(NUM_BANKS * writes + i);
                    check_value("bank address", 64'(word_addr), 64'(bank_addr[i]));
                    if (writes < beats) begin
                        check_value("bank data", 64'(model_mem[int'(word_addr)]),
                                    64'(bank_word(bank_data, i)));
                    end
                end
                writes++;
            end
            if (done) begin
                done_cycle = cycle;
                // address and data still show the final beat
                for (int i = 0; i < NUM_BANKS; i++) begin
                    word_addr = base + ADDR_W'(NUM_BANKS * (beats - 1) + i);
                    check_value("held bank address", 64'(word_addr), 64'(bank_addr[i]));
                    check_value("held bank data", 64'(model_mem[int'(word_addr)]),
                                64'(bank_word(bank_data, i)));
                end
            end
            cycle++;
        end
        // a poke on the done cycle is still high here
        if (start) begin
            @(posedge clk);
            #2;
            start = 1'b0;
        end
        assert (done_cycle >= 0) else begin
            $display("%s: no done within %0d cycles of start", test_name, STORE_TIMEOUT);
            error_count++;
        end
        check_value("write beats", 64'(beats), 64'(writes));
        // first write one cycle after start, done straight after the last write
        check_value("first write cycle", 64'(0), 64'(first_write));
        check_value("done cycle", 64'(first_write + beats), 64'(done_cycle));
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        lfsr_state = 32'h568;
        error_count = 0;
        test_base = 0;
        tests_run = 0;
        tests_failed = 0;
        nrst = 1'b0;
        start = 1'b0;
        store_op = VLSU_VSE8;
        lmul = LMUL_1;
        address = '0;
        data = '0;
        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;

        begin_test("reset");
        @(negedge clk);
        check_value("busy", 64'(0), 64'(busy));
        check_value("dm_v_write", 64'(0), 64'(dm_v_write));
        check_value("done", 64'(0), 64'(done));
        end_test();

        begin_test("unit-stride stores");
        for (int r = 0; r < 2; r++) begin
            for (int op = 0; op < 3; op++) begin
                for (int lm = 0; lm < 3; lm++) begin
                    // opcodes 7..9 are VSE8/16/32, LMUL codes 0..2
                    run_store(store_op_e'(4'(7 + op)), lmul_e'(3'(lm)), 1'b0);
                end
            end
        end
        end_test();

        begin_test("reserved lmul");
        for (int lm = 3; lm < 8; lm++) begin
            run_store(VLSU_VSE16, lmul_e'(3'(lm)), 1'b0);
        end
        end_test();

        begin_test("invalid opcode");
        for (int c = 0; c < 16; c++) begin
            if (c < 7 || c > 9) begin
                @(posedge clk);
                #2;
                start = 1'b1;
                store_op = store_op_e'(4'(c));
                @(posedge clk);
                #2;
                start = 1'b0;
                // nothing may move for 8 cycles
                repeat (8) begin
                    @(negedge clk);
                    check_value("dm_v_write", 64'(0), 64'(dm_v_write));
                    check_value("done", 64'(0), 64'(done));
                    check_value("busy", 64'(0), 64'(busy));
                end
            end
        end
        end_test();

        begin_test("start while busy");
        run_store(VLSU_VSE32, LMUL_4, 1'b1);
        run_store(VLSU_VSE8, LMUL_2, 1'b1);
        run_store(VLSU_VSE16, LMUL_1, 1'b1);
        end_test();

        // each start lands on the cycle after the previous done
        begin_test("back-to-back");
        run_store(VLSU_VSE8, LMUL_4, 1'b0);
        run_store(VLSU_VSE32, LMUL_1, 1'b0);
        run_store(VLSU_VSE16, LMUL_2, 1'b0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/vstore_pkg.sv
logic/vstore_ctrl.sv
logic/vstore_beat_counter.sv
logic/vstore_addr_gen.sv
logic/vstore_data_shift.sv
logic/vstore_unit.sv
tb/vstore_unit_asserts.sv
tb/tb_vstore_unit.sv

// ==== Makefile ====
# Verilator simulation of the vector store unit
VERILATOR ?= verilator
TOP       ?= tb_vstore_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "fail message in $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
